/* list.f */
design/board_pkg.sv
design/i2s_mic_receiver.sv
design/seg_scanner.sv
design/lab_top.sv
design/seg_static_latch.sv
design/board_top.sv
tb/board_properties.sv
tb/tb_board_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grep the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_board_top -o tb_board_top_sim \
    && ./obj_dir/tb_board_top_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

/* tb/tb_board_top.sv */
// Testbench for board_top with clock, reset, I2S microphone model, reference model and checks

`timescale 1ns/100ps
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int WAIT_LIMIT = 2 * FRAME_BITS * 2 * SCK_HALF;  // Two frames of clk
    localparam int REFRESH    = 132;                            // Display settle after valid

    logic                clk = 1'b0;
    logic                rst;
    logic [W_KEY-1:0]    button;
    logic [W_SW-1:0]     sw;
    logic                mic_sd = 1'b0;
    logic [W_LED-1:0]    led;
    logic [6:0]          hex0;
    logic [6:0]          hex1;
    logic [6:0]          hex2;
    logic [6:0]          hex3;
    i2s_ctrl_t           mic_ctrl;
    logic                mic_gnd;
    logic                mic_vcc;

    // Reference model and bookkeeping
    logic [31:0] rng = 32'h8582cb48;
    logic [15:0] model_cur = '0;
    logic [15:0] model_cur_mag = '0;
    logic [15:0] model_peak = '0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          test_errors = 0;
    bit          timed_out = 1'b0;

    // Microphone model state
    logic        sck_prev = 1'b0;
    logic        ws_prev = 1'b0;
    int          bit_idx = 0;
    logic [23:0] frame_word = '0;
    logic [23:0] next_word = '0;
    int          frames_loaded = 0;

    // Standard segment codes in gfedcba order with a in bit 0
    logic [6:0] seg_code [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                  7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    board_top dut
    (
        .clk      (clk),
        .rst      (rst),
        .button   (button),
        .sw       (sw),
        .mic_sd   (mic_sd),
        .led      (led),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .mic_ctrl (mic_ctrl),
        .mic_gnd  (mic_gnd),
        .mic_vcc  (mic_vcc)
    );

    always #10 clk = ~clk;

    // --------------------
    // I2S microphone drives a new bit after each sck fall, MSB one bit after ws falls

    always @(negedge clk)
        if (rst)
        begin
            sck_prev = 1'b0;
            ws_prev  = 1'b0;
            bit_idx  = 0;
            mic_sd   = 1'b0;
        end
        else
        begin
            if (sck_prev && !mic_ctrl.sck)
            begin
                if (ws_prev && !mic_ctrl.ws)
                begin
                    bit_idx    = 0;
                    frame_word = next_word;
                    frames_loaded++;
                end
                else
                    bit_idx++;
                mic_sd = (bit_idx >= 1 && bit_idx <= 24) ? frame_word[24 - bit_idx] : 1'b0;
            end
            sck_prev = mic_ctrl.sck;
            ws_prev  = mic_ctrl.ws;
        end

    // --------------------
    // Model functions

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [23:0] random_word();
        rng = xorshift32(rng);
        return rng[23:0];
    endfunction

    // Top 16 bits of |word| with full-scale negative clipped
    function automatic logic [15:0] magnitude_top16(input logic [23:0] word);
        int v;
        v = $signed(word);
        if (v < 0)
            v = -v;
        if (v >= (1 << 23))
            return 16'h7fff;
        return 16'(v >> 8);
    endfunction

    function automatic logic [W_LED-1:0] level_bar(input logic [15:0] mag);
        logic [W_LED-1:0] bar;
        int               top;
        top = -1;
        for (int b = 0; b < 16; b++)
            if (mag[b])
                top = b;
        for (int i = 0; i < W_LED; i++)
            bar[i] = (top >= 5 + i);
        return bar;
    endfunction

    // Returns {found, nibble} for one active-low HEX pattern
    function automatic logic [4:0] decode_digit(input logic [6:0] hex);
        for (int n = 0; n < 16; n++)
            if (~hex == seg_code[n])
                return {1'b1, 4'(n)};
        return 5'b0;
    endfunction

    // --------------------
    // Compare tasks

    task automatic check_hex(input logic [6:0] h0, input logic [6:0] h1, input logic [6:0] h2,
                             input logic [6:0] h3, input logic [15:0] expected,
                             input string what);
        logic [6:0]  pats [4];
        logic [4:0]  dec;
        logic [15:0] got;
        if (timed_out)
            return;
        pats = '{h0, h1, h2, h3};
        got  = '0;
        check_count++;
        for (int d = 0; d < 4; d++)
        begin
            dec = decode_digit(pats[d]);
            if (!dec[4])
            begin
                $display("[FAIL] %0t ns: %s: HEX%0d pattern %b is no hex digit",
                         $time, what, d, pats[d]);
                error_count++;
                return;
            end
            got[d*4 +: 4] = dec[3:0];
        end
        if (got !== expected)
        begin
            $display("[FAIL] %0t ns: %s: display %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic check_blank(input logic [6:0] h0, input logic [6:0] h1,
                               input logic [6:0] h2, input logic [6:0] h3);
        check_count++;
        if ({h3, h2, h1, h0} !== '1)
        begin
            $display("[FAIL] %0t ns: HEX not blank: %b %b %b %b", $time, h3, h2, h1, h0);
            error_count++;
        end
    endtask

    task automatic check_led(input logic [W_LED-1:0] got, input logic [W_LED-1:0] expected,
                             input string what);
        if (timed_out)
            return;
        check_count++;
        if (got !== expected)
        begin
            $display("[FAIL] %0t ns: %s: led %b, expected %b", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic check_mic_pins(input i2s_ctrl_t got, input i2s_ctrl_t expected,
                                  input logic gnd, input logic vcc);
        check_count++;
        if (got !== expected || gnd !== 1'b0 || vcc !== 1'b1)
        begin
            $display("[FAIL] %0t ns: mic sck/ws/lr %b gnd %b vcc %b, expected %b gnd 0 vcc 1",
                     $time, got, gnd, vcc, expected);
            error_count++;
        end
    endtask

    task automatic check_sample(input mic_sample_t got, input logic [23:0] expected);
        if (timed_out)
            return;
        check_count++;
        if (!got.valid || got.value !== expected)
        begin
            $display("[FAIL] %0t ns: sample %h valid %b, expected %h",
                     $time, got.value, got.valid, expected);
            error_count++;
        end
    endtask

    // --------------------
    // Sequencing helpers

    task automatic send_frame(input logic [23:0] word);
        int          start;
        int          n;
        logic [15:0] mag;
        if (timed_out)
            return;
        next_word = word;
        start     = frames_loaded;
        n         = 0;
        while (frames_loaded == start && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (frames_loaded == start)
        begin
            $display("Timeout: the receiver started no new I2S frame");
            timed_out = 1'b1;
            return;
        end
        n = 0;
        while (!dut.u_mic.sample.valid && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!dut.u_mic.sample.valid)
        begin
            $display("Timeout: the receiver never flagged a sample");
            timed_out = 1'b1;
            return;
        end
        check_sample(dut.u_mic.sample, word);
        mag = magnitude_top16(word);
        if (button[0])  // Freeze key not pressed
        begin
            model_cur     = word[23:8];
            model_cur_mag = mag;
        end
        if (mag > model_peak)
            model_peak = mag;
        repeat (REFRESH) @(negedge clk);
    endtask

    task automatic press_clear();
        @(negedge clk);
        button[1] = 1'b0;
        @(negedge clk);
        button[1] = 1'b1;
        model_peak = '0;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_errors && !timed_out)
            $display("Test %-16s ok", name);
        else
            $display("Test %-16s %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // --------------------
    // Tests

    task automatic test_sample_and_level();
        logic [23:0] word;
        for (int n = 0; n <= 20; n++)
        begin
            word = (n == 20) ? 24'h800000 : random_word();  // Last one is full-scale negative
            send_frame(word);
            check_hex(hex0, hex1, hex2, hex3, word[23:8], "sample");
            check_led(led, level_bar(magnitude_top16(word)), "level bar");
        end
        end_test("sample display");
    endtask

    task automatic test_freeze();
        logic [15:0] held;
        held = model_cur;
        @(negedge clk);
        button[0] = 1'b0;
        for (int n = 0; n < 3; n++)
        begin
            send_frame(random_word());
            check_hex(hex0, hex1, hex2, hex3, held, "freeze");
            check_led(led, level_bar(model_cur_mag), "freeze bar");
        end
        @(negedge clk);
        button[0] = 1'b1;
        end_test("freeze");
    endtask

    task automatic test_peak();
        logic [23:0] word;
        @(negedge clk);
        sw[0] = 1'b1;
        press_clear();
        for (int n = 0; n < 6; n++)
        begin
            send_frame(random_word());
            check_hex(hex0, hex1, hex2, hex3, model_peak, "peak");
        end
        press_clear();
        word = random_word();
        send_frame(word);
        check_hex(hex0, hex1, hex2, hex3, magnitude_top16(word), "peak after clear");
        @(negedge clk);
        sw[0] = 1'b0;
        end_test("peak mode");
    endtask

    task automatic test_segments();
        logic [23:0] word;
        logic [23:0] noise;
        noise = random_word();
        word  = {16'h0123, noise[7:0]};
        send_frame(word);
        check_hex(hex0, hex1, hex2, hex3, 16'h0123, "segments 0-3");
        noise = random_word();
        word  = {16'h89ab, noise[7:0]};
        send_frame(word);
        check_hex(hex0, hex1, hex2, hex3, 16'h89ab, "segments 8-b");
        noise = random_word();
        word  = {16'hcdef, noise[7:0]};
        send_frame(word);
        check_hex(hex0, hex1, hex2, hex3, 16'hcdef, "segments c-f");
        noise = random_word();
        word  = {16'h4567, noise[7:0]};
        send_frame(word);
        check_hex(hex0, hex1, hex2, hex3, 16'h4567, "segments 4-7");
        end_test("segment table");
    endtask

    initial
    begin
        rst    = 1'b1;
        button = '1;
        sw     = '0;
        repeat (4) @(negedge clk);
        check_blank(hex0, hex1, hex2, hex3);
        check_led(led, '0, "reset led");
        check_mic_pins(mic_ctrl, '0, mic_gnd, mic_vcc);
        end_test("reset state");
        rst = 1'b0;

        test_sample_and_level();
        test_freeze();
        test_peak();
        test_segments();

        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (timed_out || error_count != 0)
            $display("Result: FAILED");
        else
            $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/board_properties.sv */
// Bound concurrent assertions for I2S clocking, the sample pulse and the digit select

`timescale 1ns/100ps
`default_nettype none

module board_properties
(
    input logic                          clk,
    input logic                          rst,
    input logic                          sck,
    input logic                          ws,
    input logic                          valid,
    input logic [board_pkg::W_DIGIT-1:0] digit
);

    // --------------------
    // I2S timing

    ws_on_sck_fall: assert property (
        @(posedge clk) disable iff (rst) $changed(ws) |-> $fell(sck)
    ) else $error("ws changed while sck did not fall");

    valid_single: assert property (
        @(posedge clk) disable iff (rst) valid |=> !valid
    ) else $error("sample valid held for more than one cycle");

    // --------------------
    // Scanner

    digit_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(digit)
    ) else $error("digit select is not one-hot");

endmodule

// Receiver clocks and sample pulse together with the scanner's digit select
bind board_top board_properties u_props
(
    .clk   (clk),
    .rst   (rst),
    .sck   (mic_ctrl.sck),
    .ws    (mic_ctrl.ws),
    .valid (sample.valid),
    .digit (seg.digit)
);

`default_nettype wire

/* design/board_top.sv */
// Board top: button inversion, microphone power pins and block interconnect

`timescale 1ns/100ps
`default_nettype none

module board_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [board_pkg::W_KEY-1:0] button,  // Active low
    input  logic [board_pkg::W_SW-1:0]  sw,
    input  logic                        mic_sd,
    output logic [board_pkg::W_LED-1:0] led,
    output logic [6:0]                  hex0,
    output logic [6:0]                  hex1,
    output logic [6:0]                  hex2,
    output logic [6:0]                  hex3,
    output board_pkg::i2s_ctrl_t        mic_ctrl,
    output logic                        mic_gnd,
    output logic                        mic_vcc
);

    import board_pkg::*;

    logic [W_KEY-1:0] key;
    mic_sample_t      sample;
    seg_bus_t         seg;

    assign key = ~button;

    // Microphone powered from I/O pins
    assign mic_gnd = 1'b0;
    assign mic_vcc = 1'b1;

    // --------------------

    i2s_mic_receiver u_mic
    (
        .clk    (clk),
        .rst    (rst),
        .sd     (mic_sd),
        .ctrl   (mic_ctrl),
        .sample (sample)
    );

    lab_top u_lab
    (
        .clk    (clk),
        .rst    (rst),
        .key    (key),
        .sw     (sw),
        .sample (sample),
        .led    (led),
        .seg    (seg)
    );

    seg_static_latch u_latch
    (
        .clk  (clk),
        .rst  (rst),
        .seg  (seg),
        .hex0 (hex0),
        .hex1 (hex1),
        .hex2 (hex2),
        .hex3 (hex3)
    );

endmodule

`default_nettype wire

/* design/seg_static_latch.sv */
// Sticky flops that turn the scanned segment bus into four static HEX outputs

`timescale 1ns/100ps
`default_nettype none

module seg_static_latch
(
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::seg_bus_t seg,
    output logic [6:0]          hex0,
    output logic [6:0]          hex1,
    output logic [6:0]          hex2,
    output logic [6:0]          hex3
);

    import board_pkg::*;

    logic [6:0] gfedcba;
    logic [6:0] pattern;
    logic [6:0] hex_q [W_DIGIT];

    // Reverse so that segment a lands in bit 0
    always_comb
        for (int i = 0; i < 7; i++)
            gfedcba[i] = seg.abcdefgh[7 - i];

    assign pattern = ~gfedcba;  // Active low with the dot dropped

    // Each digit keeps its pattern until scanned again
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            for (int i = 0; i < W_DIGIT; i++)
                hex_q[i] <= '1;  // Blank
        end
        else
        begin
            for (int i = 0; i < W_DIGIT; i++)
                if (seg.digit[i])
                    hex_q[i] <= pattern;
        end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

endmodule

`default_nettype wire

/* design/lab_top.sv */
// Microphone lab core: current/peak registers, display mode and LED level bar

`timescale 1ns/100ps
`default_nettype none

module lab_top
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [board_pkg::W_KEY-1:0] key,
    input  logic [board_pkg::W_SW-1:0]  sw,
    input  board_pkg::mic_sample_t  sample,
    output logic [board_pkg::W_LED-1:0] led,
    output board_pkg::seg_bus_t     seg
);

    import board_pkg::*;

    localparam int W_SHOW   = 4 * W_DIGIT;  // Shown value width
    localparam int LED_BASE = 5;            // Lowest magnitude bit on the bar

    logic [W_SAMPLE-1:0] abs_val;
    logic [W_SHOW-1:0]   mag;
    logic [W_SHOW-1:0]   cur_q;
    logic [W_SHOW-1:0]   cur_mag_q;
    logic [W_SHOW-1:0]   peak_q;
    logic [W_SHOW-1:0]   shown;
    disp_mode_e          mode;

    // --------------------
    // Magnitude of the incoming sample

    assign abs_val = sample.value[W_SAMPLE-1] ? ~sample.value + 1'b1 : sample.value;
    assign mag     = abs_val[W_SAMPLE-1] ? {1'b0, {(W_SHOW-1){1'b1}}}  // -2^23 saturates
                                         : abs_val[W_SAMPLE-1 -: W_SHOW];

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            cur_q     <= '0;
            cur_mag_q <= '0;
            peak_q    <= '0;
        end
        else
        begin
            if (sample.valid && !key[0])  // key[0] freezes the display
            begin
                cur_q     <= sample.value[W_SAMPLE-1 -: W_SHOW];
                cur_mag_q <= mag;
            end

            if (key[1])
                peak_q <= '0;
            else if (sample.valid && mag > peak_q)
                peak_q <= mag;
        end

    // Thermometer bar from the leading one of the magnitude
    for (genvar i = 0; i < W_LED; i++)
    begin : g_bar
        assign led[i] = |cur_mag_q[W_SHOW-1:LED_BASE+i];
    end

    assign mode  = sw[0] ? DISP_PEAK : DISP_SAMPLE;
    assign shown = (mode == DISP_PEAK) ? peak_q : cur_q;

    seg_scanner u_scanner
    (
        .clk   (clk),
        .rst   (rst),
        .value (shown),
        .seg   (seg)
    );

endmodule

`default_nettype wire

/* design/seg_scanner.sv */
// Scanned seven-segment driver with rotating digit select and hex encoder

`timescale 1ns/100ps
`default_nettype none

module seg_scanner
(
    input  logic                [15:0] value,
    input  logic                       clk,
    input  logic                       rst,
    output board_pkg::seg_bus_t        seg
);

    import board_pkg::*;

    localparam int SCAN_W = $clog2(SCAN_CYCLES);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_CYCLES - 1);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [W_DIGIT-1:0] digit_q;
    logic [3:0]         nibble;

    // Segments in abcdefg order, a in the MSB
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0:    hex_to_seg = 7'b1111110;
            4'h1:    hex_to_seg = 7'b0110000;
            4'h2:    hex_to_seg = 7'b1101101;
            4'h3:    hex_to_seg = 7'b1111001;
            4'h4:    hex_to_seg = 7'b0110011;
            4'h5:    hex_to_seg = 7'b1011011;
            4'h6:    hex_to_seg = 7'b1011111;
            4'h7:    hex_to_seg = 7'b1110000;
            4'h8:    hex_to_seg = 7'b1111111;
            4'h9:    hex_to_seg = 7'b1111011;
            4'ha:    hex_to_seg = 7'b1110111;
            4'hb:    hex_to_seg = 7'b0011111;
            4'hc:    hex_to_seg = 7'b1001110;
            4'hd:    hex_to_seg = 7'b0111101;
            4'he:    hex_to_seg = 7'b1001111;
            default: hex_to_seg = 7'b1000111;  // F
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            scan_cnt <= '0;
            digit_q  <= W_DIGIT'(1);
        end
        else if (scan_cnt == SCAN_LAST)
        begin
            scan_cnt <= '0;
            digit_q  <= {digit_q[W_DIGIT-2:0], digit_q[W_DIGIT-1]};  // 0, 1, 2, 3, 0 ...
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end

    // Nibble of the selected digit
    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < W_DIGIT; i++)
            if (digit_q[i])
                nibble = value[i*4 +: 4];
    end

    assign seg.abcdefgh = {hex_to_seg(nibble), 1'b0};  // Dot off
    assign seg.digit    = digit_q;

endmodule

`default_nettype wire

/* design/i2s_mic_receiver.sv */
// I2S master receiver: sck/ws generation and 24-bit left-channel capture

`timescale 1ns/100ps
`default_nettype none

module i2s_mic_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sd,
    output board_pkg::i2s_ctrl_t   ctrl,
    output board_pkg::mic_sample_t sample
);

    import board_pkg::*;

    localparam int DIV_W = $clog2(SCK_HALF);
    localparam int BIT_W = $clog2(FRAME_BITS);

    localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(SCK_HALF - 1);
    localparam logic [BIT_W-1:0] FRAME_LAST = BIT_W'(FRAME_BITS - 1);
    localparam logic [BIT_W-1:0] HALF_FRAME = BIT_W'(FRAME_BITS / 2);
    localparam logic [BIT_W-1:0] LAST_BIT   = BIT_W'(W_SAMPLE);  // Bit 0 is the I2S delay slot

    logic [DIV_W-1:0]    div_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic [BIT_W-1:0]    bit_cnt_next;
    logic                sck_q;
    logic                ws_q;
    logic                tick;
    logic                rise_tick;
    logic                fall_tick;
    i2s_state_e          state;
    logic [W_SAMPLE-2:0] shreg;
    logic [W_SAMPLE-1:0] value_q;
    logic                valid_q;

    assign tick         = (div_cnt == DIV_LAST);
    assign rise_tick    = tick & ~sck_q;  // sck goes high, sd is sampled
    assign fall_tick    = tick &  sck_q;  // sck goes low, ws may change
    assign bit_cnt_next = (bit_cnt == FRAME_LAST) ? '0 : bit_cnt + 1'b1;

    // --------------------
    // Clock generation and FSM

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt <= '0;
            bit_cnt <= '0;
            sck_q   <= 1'b0;
            ws_q    <= 1'b0;
            state   <= I2S_WAIT;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (tick)
                sck_q <= ~sck_q;

            if (fall_tick)
            begin
                bit_cnt <= bit_cnt_next;
                ws_q    <= (bit_cnt_next >= HALF_FRAME);  // High for the right half
            end

            case (state)
                I2S_WAIT:
                    if (rise_tick && bit_cnt == '0)
                        state <= I2S_SHIFT;
                I2S_SHIFT:
                    if (rise_tick && bit_cnt == LAST_BIT)
                    begin
                        state   <= I2S_SKIP;
                        valid_q <= 1'b1;
                    end
                I2S_SKIP:
                    if (fall_tick && bit_cnt_next == '0)
                        state <= I2S_WAIT;
                default:
                    state <= I2S_WAIT;
            endcase
        end

    // --------------------
    // Data path, MSB first

    always_ff @(posedge clk)
        if (state == I2S_SHIFT && rise_tick)
        begin
            shreg <= {shreg[W_SAMPLE-3:0], sd};
            if (bit_cnt == LAST_BIT)
                value_q <= {shreg, sd};  // Held until the next frame
        end

    assign ctrl   = '{sck: sck_q, ws: ws_q, lr: 1'b0};
    assign sample = '{value: value_q, valid: valid_q};

endmodule

`default_nettype wire

/* design/board_pkg.sv */
// Board constants, sample/display/I2S structs, receiver state and display mode enums

`default_nettype none

package board_pkg;

    // --------------------
    // Board sizes

    localparam int W_KEY    = 3;
    localparam int W_SW     = 9;
    localparam int W_LED    = 10;
    localparam int W_DIGIT  = 4;
    localparam int W_SAMPLE = 24;

    // --------------------
    // Timing

    localparam int SCK_HALF    = 8;   // sck = clk / 16
    localparam int FRAME_BITS  = 64;  // 32 sck periods per channel
    localparam int SCAN_CYCLES = 32;  // Dwell time of one digit

    // --------------------
    // Buses

    typedef struct packed {
        logic signed [W_SAMPLE-1:0] value;
        logic                       valid;  // One-cycle pulse per frame
    } mic_sample_t;

    typedef struct packed {
        logic [7:0]         abcdefgh;  // Segment a in the MSB, h is the dot
        logic [W_DIGIT-1:0] digit;     // One-hot select
    } seg_bus_t;

    typedef struct packed {
        logic sck;
        logic ws;
        logic lr;  // Low selects the left channel
    } i2s_ctrl_t;

    typedef enum logic [1:0] {
        I2S_WAIT,
        I2S_SHIFT,
        I2S_SKIP
    } i2s_state_e;

    typedef enum logic {
        DISP_SAMPLE,
        DISP_PEAK
    } disp_mode_e;

endpackage

`default_nettype wire
